//--- design/decode_pkg.sv
`default_nettype none

package decode_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // one-hot alu operation, bit positions
    localparam int alu_op_w = 12;
    localparam int alu_add  = 0;
    localparam int alu_sub  = 1;
    localparam int alu_slt  = 2;
    localparam int alu_sltu = 3;
    localparam int alu_and  = 4;
    localparam int alu_nor  = 5;
    localparam int alu_or   = 6;
    localparam int alu_xor  = 7;
    localparam int alu_sll  = 8;
    localparam int alu_srl  = 9;
    localparam int alu_sra  = 10;
    localparam int alu_lui  = 11;

    // load mode: bit 0 valid, bit 1 half, bit 2 unsigned, bit 3 word
    localparam int load_mode_w = 4;
    localparam logic [load_mode_w-1:0] load_none = 4'b0000;
    localparam logic [load_mode_w-1:0] load_b    = 4'b0001;
    localparam logic [load_mode_w-1:0] load_bu   = 4'b0101;
    localparam logic [load_mode_w-1:0] load_h    = 4'b0011;
    localparam logic [load_mode_w-1:0] load_hu   = 4'b0111;
    localparam logic [load_mode_w-1:0] load_w    = 4'b1111;

    // store byte enables
    localparam int mem_we_w = 4;
    localparam logic [mem_we_w-1:0] store_none = 4'b0000;
    localparam logic [mem_we_w-1:0] store_b    = 4'b0001;
    localparam logic [mem_we_w-1:0] store_h    = 4'b0011;
    localparam logic [mem_we_w-1:0] store_w    = 4'b1111;

    // immediate kinds, decoder to operand select
    localparam logic [1:0] imm_si12 = 2'd0;
    localparam logic [1:0] imm_ui12 = 2'd1;
    localparam logic [1:0] imm_si20 = 2'd2;

    typedef struct packed {
        logic [16:0]           opcode;
        logic [reg_addr_w-1:0] rk;
        logic [reg_addr_w-1:0] rj;
        logic [reg_addr_w-1:0] rd;
    } fmt_3r_t;

    typedef struct packed {
        logic [9:0]            opcode;
        logic [11:0]           imm12;
        logic [reg_addr_w-1:0] rj;
        logic [reg_addr_w-1:0] rd;
    } fmt_2ri12_t;

    typedef struct packed {
        logic [6:0]            opcode;
        logic [19:0]           imm20;
        logic [reg_addr_w-1:0] rd;
    } fmt_1ri20_t;

    // same 32 bits, three formats
    typedef union packed {
        fmt_3r_t    fmt_3r;
        fmt_2ri12_t fmt_2ri12;
        fmt_1ri20_t fmt_1ri20;
    } inst_word_t;

endpackage

`default_nettype wire

//--- design/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder import decode_pkg::*; (
    input  inst_word_t              inst,
    output logic [alu_op_w-1:0]     alu_op,
    output logic [1:0]              imm_kind,
    output logic                    src1_is_pc,
    output logic                    src2_is_imm,
    output logic                    src2_is_rd,
    output logic                    uses_rj,
    output logic                    uses_rk,
    output logic                    gr_we,
    output logic [mem_we_w-1:0]     mem_we,
    output logic [load_mode_w-1:0]  load_mode,
    output logic                    illegal
);

    wire [16:0] op_3r  = inst.fmt_3r.opcode;
    wire [9:0]  op_12  = inst.fmt_2ri12.opcode;
    wire [6:0]  op_20  = inst.fmt_1ri20.opcode;

    // register alu, bits 31:15
    wire is_add_w  = op_3r == 17'h00020;
    wire is_sub_w  = op_3r == 17'h00022;
    wire is_slt    = op_3r == 17'h00024;
    wire is_sltu   = op_3r == 17'h00025;
    wire is_nor    = op_3r == 17'h00028;
    wire is_and    = op_3r == 17'h00029;
    wire is_or     = op_3r == 17'h0002a;
    wire is_xor    = op_3r == 17'h0002b;
    wire is_sll_w  = op_3r == 17'h0002e;
    wire is_srl_w  = op_3r == 17'h0002f;
    wire is_sra_w  = op_3r == 17'h00030;

    // shift by ui5, also matched on bits 31:15
    wire is_slli_w = op_3r == 17'h00081;
    wire is_srli_w = op_3r == 17'h00089;
    wire is_srai_w = op_3r == 17'h00091;

    // 12-bit immediate group, bits 31:22
    wire is_slti   = op_12 == 10'h008;
    wire is_sltui  = op_12 == 10'h009;
    wire is_addi_w = op_12 == 10'h00a;
    wire is_andi   = op_12 == 10'h00d;
    wire is_ori    = op_12 == 10'h00e;
    wire is_xori   = op_12 == 10'h00f;
    wire is_ld_b   = op_12 == 10'h0a0;
    wire is_ld_h   = op_12 == 10'h0a1;
    wire is_ld_w   = op_12 == 10'h0a2;
    wire is_st_b   = op_12 == 10'h0a4;
    wire is_st_h   = op_12 == 10'h0a5;
    wire is_st_w   = op_12 == 10'h0a6;
    wire is_ld_bu  = op_12 == 10'h0a8;
    wire is_ld_hu  = op_12 == 10'h0a9;

    // 20-bit immediate group, bits 31:25
    wire is_lu12i_w   = op_20 == 7'h0a;
    wire is_pcaddu12i = op_20 == 7'h0e;

    wire is_3r = is_add_w | is_sub_w | is_slt | is_sltu | is_nor | is_and | is_or
               | is_xor | is_sll_w | is_srl_w | is_sra_w;
    wire is_shift_i = is_slli_w | is_srli_w | is_srai_w;
    wire is_arith_i = is_slti | is_sltui | is_addi_w;
    wire is_logic_i = is_andi | is_ori | is_xori;
    wire is_u20     = is_lu12i_w | is_pcaddu12i;
    wire is_load    = is_ld_b | is_ld_h | is_ld_w | is_ld_bu | is_ld_hu;
    wire is_store   = is_st_b | is_st_h | is_st_w;

    wire legal = is_3r | is_shift_i | is_arith_i | is_logic_i | is_u20 | is_load | is_store;

    // no match leaves every alu bit low
    assign alu_op[alu_add]  = is_add_w | is_addi_w | is_load | is_store | is_pcaddu12i;
    assign alu_op[alu_sub]  = is_sub_w;
    assign alu_op[alu_slt]  = is_slt | is_slti;
    assign alu_op[alu_sltu] = is_sltu | is_sltui;
    assign alu_op[alu_and]  = is_and | is_andi;
    assign alu_op[alu_nor]  = is_nor;
    assign alu_op[alu_or]   = is_or | is_ori;
    assign alu_op[alu_xor]  = is_xor | is_xori;
    assign alu_op[alu_sll]  = is_sll_w | is_slli_w;
    assign alu_op[alu_srl]  = is_srl_w | is_srli_w;
    assign alu_op[alu_sra]  = is_sra_w | is_srai_w;
    assign alu_op[alu_lui]  = is_lu12i_w;

    assign imm_kind = is_logic_i ? imm_ui12 :
                      is_u20     ? imm_si20 : imm_si12;

    assign src1_is_pc  = is_pcaddu12i;
    assign src2_is_imm = legal & ~is_3r;
    assign src2_is_rd  = is_store;

    // uses_rk covers the second port, rd for stores
    assign uses_rj = legal & ~is_u20;
    assign uses_rk = is_3r | is_store;

    assign gr_we   = legal & ~is_store;
    assign illegal = ~legal;

    assign mem_we = is_st_w ? store_w :
                    is_st_h ? store_h :
                    is_st_b ? store_b : store_none;

    assign load_mode = is_ld_w  ? load_w  :
                       is_ld_hu ? load_hu :
                       is_ld_h  ? load_h  :
                       is_ld_bu ? load_bu :
                       is_ld_b  ? load_b  : load_none;

endmodule

`default_nettype wire

//--- design/operand_select.sv
`timescale 1ns/1ps
`default_nettype none

module operand_select import decode_pkg::*; (
    input  inst_word_t         inst,
    input  logic [xlen-1:0]    pc,
    input  logic [1:0]         imm_kind,
    input  logic               src1_is_pc,
    input  logic               src2_is_imm,
    input  logic [xlen-1:0]    rj_value,
    input  logic [xlen-1:0]    rkd_value,
    output logic [xlen-1:0]    alu_src1,
    output logic [xlen-1:0]    alu_src2,
    output logic [xlen-1:0]    store_data
);

    logic [11:0]     imm12;
    logic [19:0]     imm20;
    logic [xlen-1:0] imm;

    assign imm12 = inst.fmt_2ri12.imm12;
    assign imm20 = inst.fmt_1ri20.imm20;

    // shifts take si12 too, the alu only looks at the low five bits
    always_comb begin
        case (imm_kind)
            imm_ui12: begin
                imm = {{(xlen-12){1'b0}}, imm12};
            end
            imm_si20: begin
                imm = {imm20, 12'b0};
            end
            default: begin
                imm = {{(xlen-12){imm12[11]}}, imm12};
            end
        endcase
    end

    assign alu_src1 = src1_is_pc ? pc : rj_value;
    assign alu_src2 = src2_is_imm ? imm : rkd_value;

    // second port reads rd for stores
    assign store_data = rkd_value;

endmodule

`default_nettype wire

//--- design/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile import decode_pkg::*; (
    input  logic                   clk,
    input  logic [reg_addr_w-1:0]  raddr1,
    input  logic [reg_addr_w-1:0]  raddr2,
    input  logic                   we,
    input  logic [reg_addr_w-1:0]  waddr,
    input  logic [xlen-1:0]        wdata,
    output logic [xlen-1:0]        rdata1,
    output logic [xlen-1:0]        rdata2
);

    localparam int depth = 1 << reg_addr_w;

    logic [xlen-1:0] mem [depth];

    // r0 may be written, reads mask it
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : mem[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : mem[raddr2];

endmodule

`default_nettype wire

//--- design/bypass_unit.sv
`timescale 1ns/1ps
`default_nettype none

module bypass_unit import decode_pkg::*; (
    input  logic [reg_addr_w-1:0]  raddr1,
    input  logic [reg_addr_w-1:0]  raddr2,
    input  logic                   uses_rj,
    input  logic                   uses_rk,
    input  logic [xlen-1:0]        rf_rdata1,
    input  logic [xlen-1:0]        rf_rdata2,
    input  logic                   e_we,
    input  logic [reg_addr_w-1:0]  e_dest,
    input  logic                   m_we,
    input  logic [reg_addr_w-1:0]  m_dest,
    input  logic [xlen-1:0]        m_wdata,
    input  logic                   w_we,
    input  logic [reg_addr_w-1:0]  w_dest,
    input  logic [xlen-1:0]        w_wdata,
    output logic [xlen-1:0]        rj_value,
    output logic [xlen-1:0]        rkd_value,
    output logic                   stall
);

    // r0 never matches a producer
    function automatic logic hit(
        input logic [reg_addr_w-1:0] addr,
        input logic                  we,
        input logic [reg_addr_w-1:0] dest
    );
        return we && (dest == addr) && (addr != '0);
    endfunction

    // memory stage is newer than write-back
    always_comb begin
        if (hit(raddr1, m_we, m_dest)) begin
            rj_value = m_wdata;
        end else if (hit(raddr1, w_we, w_dest)) begin
            rj_value = w_wdata;
        end else begin
            rj_value = rf_rdata1;
        end
    end

    always_comb begin
        if (hit(raddr2, m_we, m_dest)) begin
            rkd_value = m_wdata;
        end else if (hit(raddr2, w_we, w_dest)) begin
            rkd_value = w_wdata;
        end else begin
            rkd_value = rf_rdata2;
        end
    end

    // execute result not ready yet
    assign stall = (uses_rj && hit(raddr1, e_we, e_dest))
                || (uses_rk && hit(raddr2, e_we, e_dest));

endmodule

`default_nettype wire

//--- design/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage import decode_pkg::*; (
    input  logic                     clk,
    input  logic                     rstn,

    input  logic                     in_valid,
    output logic                     in_ready,
    input  logic [xlen-1:0]          in_pc,
    input  logic [xlen-1:0]          in_inst,

    output logic                     out_valid,
    input  logic                     out_ready,
    output logic [xlen-1:0]          out_pc,
    output logic [alu_op_w-1:0]      out_alu_op,
    output logic [xlen-1:0]          out_src1,
    output logic [xlen-1:0]          out_src2,
    output logic [xlen-1:0]          out_store_data,
    output logic                     out_gr_we,
    output logic [mem_we_w-1:0]      out_mem_we,
    output logic [load_mode_w-1:0]   out_load_mode,
    output logic [reg_addr_w-1:0]    out_dest,
    output logic                     out_illegal,

    input  logic                     e_we,
    input  logic [reg_addr_w-1:0]    e_dest,
    input  logic                     m_we,
    input  logic [reg_addr_w-1:0]    m_dest,
    input  logic [xlen-1:0]          m_wdata,
    input  logic                     w_we,
    input  logic [reg_addr_w-1:0]    w_dest,
    input  logic [xlen-1:0]          w_wdata
);

    logic            valid_q;
    logic [xlen-1:0] pc_q;
    inst_word_t      inst_q;

    logic [1:0]            imm_kind;
    logic                  src1_is_pc;
    logic                  src2_is_imm;
    logic                  src2_is_rd;
    logic                  uses_rj;
    logic                  uses_rk;
    logic [reg_addr_w-1:0] raddr1;
    logic [reg_addr_w-1:0] raddr2;
    logic [xlen-1:0]       rf_rdata1;
    logic [xlen-1:0]       rf_rdata2;
    logic [xlen-1:0]       rj_value;
    logic [xlen-1:0]       rkd_value;
    logic                  stall;

    // stage register holds at most one instruction
    assign out_valid = valid_q && !stall;
    assign in_ready  = !valid_q || (out_valid && out_ready);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= 1'b0;
        end else if (in_ready) begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            pc_q   <= in_pc;
            inst_q <= in_inst;
        end
    end

    assign raddr1 = inst_q.fmt_3r.rj;
    assign raddr2 = src2_is_rd ? inst_q.fmt_3r.rd : inst_q.fmt_3r.rk;

    assign out_pc   = pc_q;
    assign out_dest = inst_q.fmt_3r.rd;

    inst_decoder inst_decoder_inst (
        .inst        (inst_q),
        .alu_op      (out_alu_op),
        .imm_kind    (imm_kind),
        .src1_is_pc  (src1_is_pc),
        .src2_is_imm (src2_is_imm),
        .src2_is_rd  (src2_is_rd),
        .uses_rj     (uses_rj),
        .uses_rk     (uses_rk),
        .gr_we       (out_gr_we),
        .mem_we      (out_mem_we),
        .load_mode   (out_load_mode),
        .illegal     (out_illegal)
    );

    regfile regfile_inst (
        .clk    (clk),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .we     (w_we),
        .waddr  (w_dest),
        .wdata  (w_wdata),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    bypass_unit bypass_unit_inst (
        .raddr1    (raddr1),
        .raddr2    (raddr2),
        .uses_rj   (uses_rj),
        .uses_rk   (uses_rk),
        .rf_rdata1 (rf_rdata1),
        .rf_rdata2 (rf_rdata2),
        .e_we      (e_we),
        .e_dest    (e_dest),
        .m_we      (m_we),
        .m_dest    (m_dest),
        .m_wdata   (m_wdata),
        .w_we      (w_we),
        .w_dest    (w_dest),
        .w_wdata   (w_wdata),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .stall     (stall)
    );

    operand_select operand_select_inst (
        .inst        (inst_q),
        .pc          (pc_q),
        .imm_kind    (imm_kind),
        .src1_is_pc  (src1_is_pc),
        .src2_is_imm (src2_is_imm),
        .rj_value    (rj_value),
        .rkd_value   (rkd_value),
        .alu_src1    (out_src1),
        .alu_src2    (out_src2),
        .store_data  (out_store_data)
    );

endmodule

`default_nettype wire

//--- testbench/decode_model.svh
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// expected bundle for one instruction in the stage
typedef struct packed {
    logic [31:0] pc;
    logic [11:0] alu_op;
    logic [31:0] src1;
    logic [31:0] src2;
    logic [31:0] store_data;
    logic        gr_we;
    logic [3:0]  mem_we;
    logic [3:0]  load_mode;
    logic [4:0]  dest;
    logic        illegal;
    logic        stall;
} expect_t;

// mirror of the register file contents
logic [31:0] shadow [32];

// opcodes from the isa tables, 3r group and shifts by ui5
function automatic logic [16:0] op3r_at(input int idx);
    case (idx)
        0: return 17'h00020;
        1: return 17'h00022;
        2: return 17'h00024;
        3: return 17'h00025;
        4: return 17'h00028;
        5: return 17'h00029;
        6: return 17'h0002a;
        7: return 17'h0002b;
        8: return 17'h0002e;
        9: return 17'h0002f;
        10: return 17'h00030;
        11: return 17'h00081;
        12: return 17'h00089;
        default: return 17'h00091;
    endcase
endfunction

// 0..5 immediate alu, 6..13 loads and stores
function automatic logic [9:0] op12_at(input int idx);
    case (idx)
        0: return 10'h008;
        1: return 10'h009;
        2: return 10'h00a;
        3: return 10'h00d;
        4: return 10'h00e;
        5: return 10'h00f;
        6: return 10'h0a0;
        7: return 10'h0a1;
        8: return 10'h0a2;
        9: return 10'h0a4;
        10: return 10'h0a5;
        11: return 10'h0a6;
        12: return 10'h0a8;
        default: return 10'h0a9;
    endcase
endfunction

function automatic logic [6:0] op20_at(input int idx);
    return (idx == 0) ? 7'h0a : 7'h0e;
endfunction

function automatic logic [31:0] enc_3r(input logic [16:0] op, input logic [4:0] rk,
                                       input logic [4:0] rj, input logic [4:0] rd);
    return {op, rk, rj, rd};
endfunction

function automatic logic [31:0] enc_2ri12(input logic [9:0] op, input logic [11:0] imm,
                                          input logic [4:0] rj, input logic [4:0] rd);
    return {op, imm, rj, rd};
endfunction

function automatic logic [31:0] enc_1ri20(input logic [6:0] op, input logic [19:0] imm,
                                          input logic [4:0] rd);
    return {op, imm, rd};
endfunction

function automatic logic [11:0] onehot(input int pos);
    return 12'b1 << pos;
endfunction

// memory result is newer than write-back
function automatic logic [31:0] port_value(input logic [4:0] addr,
                                           input logic m_we, input logic [4:0] m_dest,
                                           input logic [31:0] m_wdata,
                                           input logic w_we, input logic [4:0] w_dest,
                                           input logic [31:0] w_wdata);
    if (addr == 5'd0) begin
        return 32'h0;
    end else if (m_we && m_dest == addr) begin
        return m_wdata;
    end else if (w_we && w_dest == addr) begin
        return w_wdata;
    end
    return shadow[addr];
endfunction

function automatic expect_t ref_decode(input logic [31:0] w, input logic [31:0] pc,
                                       input logic e_we, input logic [4:0] e_dest,
                                       input logic m_we, input logic [4:0] m_dest,
                                       input logic [31:0] m_wdata,
                                       input logic w_we, input logic [4:0] w_dest,
                                       input logic [31:0] w_wdata);
    expect_t     x;
    logic        legal;
    logic        is3r;
    logic        isst;
    logic        isu20;
    logic [4:0]  a2;
    logic [31:0] imm;
    logic [31:0] v1;
    logic [31:0] v2;
    x = '0;
    case (w[31:15])
        17'h00020: x.alu_op = onehot(alu_add);
        17'h00022: x.alu_op = onehot(alu_sub);
        17'h00024: x.alu_op = onehot(alu_slt);
        17'h00025: x.alu_op = onehot(alu_sltu);
        17'h00028: x.alu_op = onehot(alu_nor);
        17'h00029: x.alu_op = onehot(alu_and);
        17'h0002a: x.alu_op = onehot(alu_or);
        17'h0002b: x.alu_op = onehot(alu_xor);
        17'h0002e, 17'h00081: x.alu_op = onehot(alu_sll);
        17'h0002f, 17'h00089: x.alu_op = onehot(alu_srl);
        17'h00030, 17'h00091: x.alu_op = onehot(alu_sra);
        default: x.alu_op = '0;
    endcase
    is3r = (x.alu_op != '0) && (w[31:15] < 17'h00040);
    // the three opcode groups never overlap
    case (w[31:22])
        10'h008: x.alu_op = onehot(alu_slt);
        10'h009: x.alu_op = onehot(alu_sltu);
        10'h00a, 10'h0a0, 10'h0a1, 10'h0a2, 10'h0a4, 10'h0a5, 10'h0a6, 10'h0a8, 10'h0a9:
            x.alu_op = onehot(alu_add);
        10'h00d: x.alu_op = onehot(alu_and);
        10'h00e: x.alu_op = onehot(alu_or);
        10'h00f: x.alu_op = onehot(alu_xor);
        default: ;
    endcase
    case (w[31:22])
        10'h0a0: x.load_mode = load_b;
        10'h0a1: x.load_mode = load_h;
        10'h0a2: x.load_mode = load_w;
        10'h0a8: x.load_mode = load_bu;
        10'h0a9: x.load_mode = load_hu;
        10'h0a4: x.mem_we = store_b;
        10'h0a5: x.mem_we = store_h;
        10'h0a6: x.mem_we = store_w;
        default: ;
    endcase
    isu20 = (w[31:25] == 7'h0a) || (w[31:25] == 7'h0e);
    if (w[31:25] == 7'h0a) begin
        x.alu_op = onehot(alu_lui);
    end else if (w[31:25] == 7'h0e) begin
        x.alu_op = onehot(alu_add);
    end
    legal = x.alu_op != '0;
    isst  = x.mem_we != '0;
    if (w[31:22] >= 10'h00d && w[31:22] <= 10'h00f) begin
        imm = {20'h0, w[21:10]};
    end else if (isu20) begin
        imm = {w[24:5], 12'h0};
    end else begin
        imm = {{20{w[21]}}, w[21:10]};
    end
    a2 = isst ? w[4:0] : w[14:10];
    v1 = port_value(w[9:5], m_we, m_dest, m_wdata, w_we, w_dest, w_wdata);
    v2 = port_value(a2, m_we, m_dest, m_wdata, w_we, w_dest, w_wdata);
    x.pc         = pc;
    x.src1       = (w[31:25] == 7'h0e) ? pc : v1;
    x.src2       = (legal && !is3r) ? imm : v2;
    x.store_data = v2;
    x.gr_we      = legal && !isst;
    x.dest       = w[4:0];
    x.illegal    = !legal;
    x.stall      = e_we && ((legal && !isu20 && e_dest == w[9:5] && w[9:5] != 5'd0)
                 || ((is3r || isst) && e_dest == a2 && a2 != 5'd0));
    return x;
endfunction

`endif

//--- testbench/decode_tb.sv
`timescale 1ns/1ps
`default_nettype none

module decode_tb import decode_pkg::*; ;

    localparam int n_tests = 600;

    logic        clk;
    logic        rstn;
    logic        in_valid;
    logic        in_ready;
    logic [31:0] in_pc;
    logic [31:0] in_inst;
    logic        out_valid;
    logic        out_ready;
    logic [31:0] out_pc;
    logic [11:0] out_alu_op;
    logic [31:0] out_src1;
    logic [31:0] out_src2;
    logic [31:0] out_store_data;
    logic        out_gr_we;
    logic [3:0]  out_mem_we;
    logic [3:0]  out_load_mode;
    logic [4:0]  out_dest;
    logic        out_illegal;
    logic        e_we;
    logic [4:0]  e_dest;
    logic        m_we;
    logic [4:0]  m_dest;
    logic [31:0] m_wdata;
    logic        w_we;
    logic [4:0]  w_dest;
    logic [31:0] w_wdata;

    integer      seed;
    int          done_count;
    logic        accepted;
    logic [31:0] pend_word [$];
    logic [31:0] pend_pc [$];

    `include "decode_model.svh"

    expect_t x;

    decode_stage decode_stage_inst (.*);

    always #2 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("ERROR: %s got 0x%h expected 0x%h", name, got, want);
            $display("Simulation finished: FAIL");
            $fatal(1);
        end
    endtask

    // samples pre-edge values then updates the queue and shadow
    always @(posedge clk) begin
        if (rstn) begin
            if (pend_word.size() > 0) begin
                x = ref_decode(pend_word[0], pend_pc[0], e_we, e_dest, m_we, m_dest,
                               m_wdata, w_we, w_dest, w_wdata);
                check_value("out_valid", out_valid, !x.stall);
                check_value("in_ready", in_ready, out_ready && !x.stall);
                if (out_valid && out_ready) begin
                    check_value("out_pc", out_pc, x.pc);
                    check_value("out_alu_op", out_alu_op, x.alu_op);
                    check_value("out_src1", out_src1, x.src1);
                    check_value("out_src2", out_src2, x.src2);
                    check_value("out_store_data", out_store_data, x.store_data);
                    check_value("out_gr_we", out_gr_we, x.gr_we);
                    check_value("out_mem_we", out_mem_we, x.mem_we);
                    check_value("out_load_mode", out_load_mode, x.load_mode);
                    check_value("out_dest", out_dest, x.dest);
                    check_value("out_illegal", out_illegal, x.illegal);
                    void'(pend_word.pop_front());
                    void'(pend_pc.pop_front());
                    done_count = done_count + 1;
                end
            end else begin
                check_value("out_valid", out_valid, 1'b0);
                check_value("in_ready", in_ready, 1'b1);
            end
            if (in_valid && in_ready) begin
                pend_word.push_back(in_inst);
                pend_pc.push_back(in_pc);
            end
            if (w_we) begin
                shadow[w_dest] = w_wdata;
            end
        end
    end

    task automatic build_word(input int kind, input bit hz, output logic [31:0] word);
        logic [31:0] r;
        logic [4:0]  rk;
        logic [4:0]  rj;
        logic [4:0]  rd;
        expect_t     probe;
        r  = $random(seed);
        // narrow register range so hazards hit often
        rk = hz ? {2'b0, r[2:0]} : r[4:0];
        rj = hz ? {2'b0, r[7:5]} : r[9:5];
        rd = hz ? {2'b0, r[12:10]} : r[14:10];
        case (kind)
            0: word = enc_3r(op3r_at({$random(seed)} % 14), rk, rj, rd);
            1: word = enc_2ri12(op12_at({$random(seed)} % 6), r[31:20], rj, rd);
            2: word = enc_2ri12(op12_at(6 + {$random(seed)} % 8), r[31:20], rj, rd);
            3: word = enc_1ri20(op20_at({$random(seed)} % 2), {r[31:15], r[2:0]}, rd);
            default: begin
                do begin
                    word  = $random(seed);
                    probe = ref_decode(word, 32'h0, 1'b0, 5'h0, 1'b0, 5'h0, 32'h0,
                                       1'b0, 5'h0, 32'h0);
                end while (!probe.illegal);
            end
        endcase
    endtask

    task automatic step(input bit hz);
        logic [31:0] r;
        @(posedge clk);
        accepted = in_valid && in_ready;
        r = $random(seed);
        out_ready <= r[31:30] != 2'b00;
        e_we    <= hz && r[1:0] == 2'b00;
        e_dest  <= {2'b0, r[4:2]};
        m_we    <= hz && r[5];
        m_dest  <= {2'b0, r[8:6]};
        m_wdata <= $random(seed);
        w_we    <= hz && r[9];
        w_dest  <= {2'b0, r[12:10]};
        w_wdata <= $random(seed);
    endtask

    initial begin
        logic [31:0] word;
        bit          hz;
        seed = 32'h75f4b644;
        clk = 1'b0;
        rstn = 1'b0;
        in_valid = 1'b0;
        in_pc = '0;
        in_inst = '0;
        out_ready = 1'b0;
        e_we = 1'b0;
        e_dest = '0;
        m_we = 1'b0;
        m_dest = '0;
        m_wdata = '0;
        w_we = 1'b0;
        w_dest = '0;
        w_wdata = '0;
        done_count = 0;
        repeat (8) @(posedge clk);
        rstn <= 1'b1;
        // fill every register through the write port
        for (int r = 0; r < 32; r++) begin
            @(posedge clk);
            w_we    <= 1'b1;
            w_dest  <= r[4:0];
            w_wdata <= $random(seed);
        end
        @(posedge clk);
        w_we <= 1'b0;
        for (int i = 0; i < n_tests; i++) begin
            hz = i >= n_tests / 2;
            build_word(i % 5, hz, word);
            in_valid <= 1'b1;
            in_inst  <= word;
            in_pc    <= $random(seed) & 32'hffff_fffc;
            do begin
                step(hz);
            end while (!accepted);
            if ({$random(seed)} % 4 == 0) begin
                in_valid <= 1'b0;
                repeat (1 + {$random(seed)} % 2) step(hz);
            end
        end
        in_valid <= 1'b0;
        while (done_count < n_tests) begin
            step(1'b0);
        end
        $display("Simulation finished: PASS");
        $finish;
    end

    initial begin
        #((n_tests * 40 + 200) * 4);
        $display("timeout: the DUT did not deliver all instructions in time");
        $display("Simulation finished: FAIL");
        $fatal(1);
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+testbench
design/decode_pkg.sv
design/inst_decoder.sv
design/operand_select.sv
design/regfile.sv
design/bypass_unit.sv
design/decode_stage.sv
testbench/decode_tb.sv

//--- Bender.yml
package:
  name: decode_stage

sources:
  - files:
      - design/decode_pkg.sv
      - design/inst_decoder.sv
      - design/operand_select.sv
      - design/regfile.sv
      - design/bypass_unit.sv
      - design/decode_stage.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/decode_tb.sv
